/* bench/ref_iss.svh */
`ifndef REF_ISS_SVH
`define REF_ISS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction encoders.
function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                reg_idx_t rd, opcode_e op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
endfunction

function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs1, reg_idx_t rs2,
                                logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_br};
endfunction

function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test program, data base address in x10.
function automatic void build_program();
    prog.delete();
    prog.push_back({20'h80000, 5'd1, op_lui});
    prog.push_back(enc_i(-5, 0, 3'b000, 2, op_imm));
    prog.push_back(enc_i(7, 0, 3'b000, 3, op_imm));
    prog.push_back(enc_i(12'h100, 0, 3'b000, 10, op_imm));
    // dependent chain, operands from memory and writeback stages.
    prog.push_back(enc_r(7'h00, 3, 2, 3'b000, 4));
    prog.push_back(enc_s(0, 4, 10, 3'b010));
    prog.push_back(enc_r(7'h20, 3, 2, 3'b000, 5));
    prog.push_back(enc_s(4, 5, 10, 3'b010));
    prog.push_back(enc_r(7'h00, 3, 2, 3'b010, 6));
    prog.push_back(enc_r(7'h00, 3, 2, 3'b011, 7));
    prog.push_back(enc_s(8, 6, 10, 3'b010));
    prog.push_back(enc_s(12, 7, 10, 3'b010));
    prog.push_back(enc_r(7'h20, 3, 1, 3'b101, 8));
    prog.push_back(enc_r(7'h00, 3, 1, 3'b101, 9));
    prog.push_back(enc_s(16, 8, 10, 3'b010));
    prog.push_back(enc_s(20, 9, 10, 3'b010));
    prog.push_back(enc_r(7'h00, 3, 3, 3'b001, 11));
    prog.push_back(enc_r(7'h00, 3, 2, 3'b100, 12));
    prog.push_back(enc_r(7'h00, 3, 2, 3'b110, 13));
    prog.push_back(enc_r(7'h00, 3, 2, 3'b111, 14));
    prog.push_back(enc_s(24, 11, 10, 3'b010));
    prog.push_back(enc_s(28, 12, 10, 3'b010));
    prog.push_back(enc_s(32, 13, 10, 3'b010));
    prog.push_back(enc_s(36, 14, 10, 3'b010));
    prog.push_back(enc_i(-1, 2, 3'b010, 15, op_imm));
    prog.push_back(enc_i(-1, 3, 3'b011, 16, op_imm));
    prog.push_back(enc_i(12'h404, 1, 3'b101, 17, op_imm));
    prog.push_back(enc_i(12'h0f0, 2, 3'b100, 18, op_imm));
    prog.push_back(enc_s(40, 15, 10, 3'b010));
    prog.push_back(enc_s(44, 16, 10, 3'b010));
    prog.push_back(enc_s(48, 17, 10, 3'b010));
    prog.push_back(enc_s(52, 18, 10, 3'b010));
    // x0 stays zero.
    prog.push_back(enc_i(55, 0, 3'b000, 0, op_imm));
    prog.push_back(enc_s(56, 0, 10, 3'b010));
    // load then immediate use.
    prog.push_back(enc_i(0, 10, 3'b010, 19, op_load));
    prog.push_back(enc_i(1, 19, 3'b000, 20, op_imm));
    prog.push_back(enc_s(60, 20, 10, 3'b010));
    // byte and half lanes.
    prog.push_back(enc_s(64, 1, 10, 3'b010));
    prog.push_back(enc_s(65, 3, 10, 3'b000));
    prog.push_back(enc_s(70, 2, 10, 3'b001));
    prog.push_back(enc_s(67, 2, 10, 3'b000));
    prog.push_back(enc_i(67, 10, 3'b000, 21, op_load));
    prog.push_back(enc_i(67, 10, 3'b100, 22, op_load));
    prog.push_back(enc_i(70, 10, 3'b001, 23, op_load));
    prog.push_back(enc_i(70, 10, 3'b101, 24, op_load));
    prog.push_back(enc_s(72, 21, 10, 3'b010));
    prog.push_back(enc_s(76, 22, 10, 3'b010));
    prog.push_back(enc_s(80, 23, 10, 3'b010));
    prog.push_back(enc_s(84, 24, 10, 3'b010));
    // taken branches skip two stores each, not-taken ones fall through.
    prog.push_back(enc_b(12, 3, 3, 3'b000));
    prog.push_back(enc_s(88, 2, 10, 3'b010));
    prog.push_back(enc_s(92, 2, 10, 3'b010));
    prog.push_back(enc_b(12, 3, 3, 3'b001));
    prog.push_back(enc_s(96, 3, 10, 3'b010));
    prog.push_back(enc_b(12, 2, 3, 3'b100));
    prog.push_back(enc_s(88, 2, 10, 3'b010));
    prog.push_back(enc_s(92, 2, 10, 3'b010));
    prog.push_back(enc_b(8, 2, 3, 3'b101));
    prog.push_back(enc_s(100, 3, 10, 3'b010));
    prog.push_back(enc_b(12, 3, 2, 3'b110));
    prog.push_back(enc_s(88, 2, 10, 3'b010));
    prog.push_back(enc_s(92, 2, 10, 3'b010));
    prog.push_back(enc_b(12, 2, 3, 3'b111));
    prog.push_back(enc_s(88, 2, 10, 3'b010));
    prog.push_back(enc_s(92, 2, 10, 3'b010));
    prog.push_back(enc_j(12, 25));
    prog.push_back(enc_s(88, 2, 10, 3'b010));
    prog.push_back(enc_s(92, 2, 10, 3'b010));
    prog.push_back(enc_s(104, 25, 10, 3'b010));
    prog.push_back(enc_j(0, 0));
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model, straight from the instruction set rules.
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
        3'b000:  return alt ? x - y : x + y;
        3'b001:  return x << y[4:0];
        3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'b011:  return (x < y) ? 32'd1 : 32'd0;
        3'b100:  return x ^ y;
        3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'b110:  return x | y;
        default: return x & y;
    endcase
endfunction

function automatic logic branch_ref(logic [2:0] f3, word_t x, word_t y);
    case (f3)
        3'b000:  return x == y;
        3'b001:  return x != y;
        3'b100:  return $signed(x) < $signed(y);
        3'b101:  return $signed(x) >= $signed(y);
        3'b110:  return x < y;
        default: return x >= y;
    endcase
endfunction

function automatic int run_reference();
    word_t r [32];
    word_t pc, next_pc, ins, a, b, imm_i, imm_s, addr, w, sd;
    mbe_t m;
    logic [2:0] f3;
    int steps;
    for (int k = 0; k < 32; k++) r[k] = '0;
    pc = reset_pc;
    steps = 0;
    while (steps < 2000) begin
        ins = prog[pc[31:2]];
        steps++;
        if (ins == enc_j(0, 0)) break;
        a = r[ins[19:15]];
        b = r[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        next_pc = pc + 32'd4;
        case (opcode_e'(ins[6:0]))
            op_lui: r[ins[11:7]] = {ins[31:12], 12'h000};
            op_jal: begin
                r[ins[11:7]] = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            op_br: begin
                if (branch_ref(f3, a, b))
                    next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            op_load: begin
                addr = a + imm_i;
                w = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'b000:  w = {{24{w[7]}}, w[7:0]};
                    3'b001:  w = {{16{w[15]}}, w[15:0]};
                    3'b100:  w = {24'd0, w[7:0]};
                    3'b101:  w = {16'd0, w[15:0]};
                    default: w = ref_mem[addr[9:2]];
                endcase
                r[ins[11:7]] = w;
            end
            op_store: begin
                addr = a + imm_s;
                case (f3)
                    3'b000: begin
                        m = 4'b0001 << addr[1:0];
                        sd = (b & 32'hff) << (8 * addr[1:0]);
                    end
                    3'b001: begin
                        m = addr[1] ? 4'b1100 : 4'b0011;
                        sd = (b & 32'hffff) << (16 * addr[1]);
                    end
                    default: begin
                        m = 4'b1111;
                        sd = b;
                    end
                endcase
                exp_addr.push_back({addr[31:2], 2'b00});
                exp_data.push_back(sd);
                exp_mbe.push_back(m);
                for (int k = 0; k < 4; k++)
                    if (m[k]) ref_mem[addr[9:2]][8*k +: 8] = sd[8*k +: 8];
            end
            op_imm: r[ins[11:7]] = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
            op_reg: r[ins[11:7]] = alu_ref(f3, ins[30], a, b);
            default: ;
        endcase
        r[0] = '0;
        pc = next_pc;
    end
    return steps;
endfunction

`endif

/* bench/tb_pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_core
    import rv_pkg::*;
;

    logic  clk, rst_n;
    logic  inst_read, inst_resp, data_read, data_write, data_resp;
    word_t inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;
    mbe_t  data_mbe;

    word_t imem [256];
    word_t dmem [256];
    word_t ref_mem [256];
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    mbe_t  exp_mbe [$];
    word_t seen_addr [$];
    word_t seen_data [$];
    mbe_t  seen_mbe [$];
    word_t lcg_state;
    int    errors, store_checks, word_checks, cycles, limit, steps, i_wait, d_wait;
    logic  timed_out;

    `include "ref_iss.svh"

    pipe_core dut0 (
        .clk(clk), .rst_n(rst_n),
        .inst_read(inst_read), .inst_addr(inst_addr), .inst_resp(inst_resp),
        .inst_rdata(inst_rdata),
        .data_read(data_read), .data_write(data_write), .data_mbe(data_mbe),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_resp(data_resp),
        .data_rdata(data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory latency of 0 to 3 cycles.
    function automatic int next_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[17:16]);
    endfunction

    function automatic word_t fill_word(int idx);
        word_t a;
        a = word_t'(idx) << 2;
        return (a * 32'h9e37_79b1) ^ {a[23:0], 8'h5c};
    endfunction

    function automatic word_t lane_mask(mbe_t m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic check_store(word_t addr, word_t data, mbe_t mbe,
                               word_t e_addr, word_t e_data, mbe_t e_mbe);
        store_checks++;
        if (addr !== e_addr || mbe !== e_mbe ||
            (data & lane_mask(e_mbe)) !== (e_data & lane_mask(e_mbe))) begin
            errors++;
            $display("Error at %0t: store %h/%h/%b, expected %h/%h/%b", $time,
                     addr, data, mbe, e_addr, e_data, e_mbe);
        end
    endtask

    task automatic check_word(word_t addr, word_t got, word_t exp);
        word_checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: memory word %h is %h, expected %h", $time,
                     addr, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory models on the falling edge.
    always @(negedge clk) begin
        inst_resp = (i_wait == 0);
        if (inst_resp) begin
            inst_rdata = imem[inst_addr[9:2]];
            i_wait = next_delay();
        end else begin
            i_wait--;
        end
        if (data_read || data_write) begin
            data_resp = (d_wait == 0);
            if (data_resp) begin
                data_rdata = dmem[data_addr[9:2]];
                if (data_write) begin
                    for (int k = 0; k < 4; k++)
                        if (data_mbe[k]) dmem[data_addr[9:2]][8*k +: 8] = data_wdata[8*k +: 8];
                    // only a cycle without fetch stall retires the store.
                    if (inst_resp) begin
                        seen_addr.push_back(data_addr);
                        seen_data.push_back(data_wdata);
                        seen_mbe.push_back(data_mbe);
                    end
                end
                d_wait = next_delay();
            end else begin
                d_wait--;
            end
        end else begin
            data_resp = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
        end
    end

    // fetch request line and run limit.
    always @(negedge clk) begin
        if (cycles > 0) begin
            check_flag("inst_read", inst_read, 1'b1);
        end
        if (limit > 0 && cycles >= limit) begin
            timed_out = 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and comparison.
    initial begin
        int idx;
        rst_n = 1'b0;
        inst_resp = 1'b0;
        inst_rdata = nop_instr;
        data_resp = 1'b0;
        data_rdata = '0;
        errors = 0;
        store_checks = 0;
        word_checks = 0;
        cycles = 0;
        limit = 0;
        timed_out = 1'b0;
        lcg_state = 32'h8c70;
        i_wait = 0;
        d_wait = 0;
        build_program();
        for (int k = 0; k < 256; k++) begin
            imem[k] = nop_instr;
            dmem[k] = fill_word(k);
            ref_mem[k] = fill_word(k);
        end
        foreach (prog[k]) imem[k] = prog[k];
        steps = run_reference();
        limit = steps * 12 + 100;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idx = 0;
        while (idx < exp_addr.size() && !timed_out) begin
            @(posedge clk);
            while (seen_addr.size() > 0 && idx < exp_addr.size()) begin
                check_store(seen_addr.pop_front(), seen_data.pop_front(),
                            seen_mbe.pop_front(), exp_addr[idx], exp_data[idx],
                            exp_mbe[idx]);
                idx++;
            end
        end
        if (!timed_out) begin
            repeat (40) @(posedge clk);
            if (seen_addr.size() > 0) begin
                errors++;
                $display("%0d stores appeared after the last expected one", seen_addr.size());
            end
            for (int k = 0; k < 256; k++) check_word(word_t'(k) << 2, dmem[k], ref_mem[k]);
        end else begin
            $display("the program never finished within %0d cycles", limit);
        end
        $display("store checks %0d, word checks %0d, errors %0d",
                 store_checks, word_checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  word_t   cmp_b,
    input  alu_op_e alu_op,
    input  br_op_e  br_op,
    output word_t   result,
    output logic    br_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'd0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // branch condition on rs1 against rs2.
    always_comb begin
        case (br_op)
            br_eq:   br_taken = a == cmp_b;
            br_ne:   br_taken = a != cmp_b;
            br_lt:   br_taken = $signed(a) < $signed(cmp_b);
            br_ge:   br_taken = $signed(a) >= $signed(cmp_b);
            br_ltu:  br_taken = a < cmp_b;
            br_geu:  br_taken = a >= cmp_b;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/control_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module control_decode
    import rv_pkg::*;
(
    input  word_t      instr,
    output opcode_e    opcode,
    output reg_idx_t   rd,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output logic [2:0] funct3,
    output alu_op_e    alu_op,
    output br_op_e     br_op,
    output logic       use_imm,
    output logic       use_pc,
    output logic       reg_write,
    output logic       mem_read,
    output logic       mem_write,
    output wb_sel_e    wb_sel,
    output word_t      imm
);

    logic writes;

    // funct3 and the alternate bit select the operation.
    function automatic alu_op_e alu_func(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct3 = instr[14:12];
    assign br_op  = br_op_e'(instr[14:12]);

    always_comb begin
        writes    = 1'b0;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        use_pc    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        wb_sel    = wb_alu;
        imm       = '0;
        case (opcode)
            op_lui: begin
                imm    = {instr[31:12], 12'h000};
                writes = 1'b1;
                wb_sel = wb_imm;
            end
            op_jal: begin
                imm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
                writes  = 1'b1;
                use_pc  = 1'b1;
                use_imm = 1'b1;
                wb_sel  = wb_pc4;
            end
            op_br: begin
                // alu sees rs1 and rs2 so the compare has both registers.
                imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
                alu_op = alu_sub;
            end
            op_load: begin
                imm      = {{20{instr[31]}}, instr[31:20]};
                writes   = 1'b1;
                use_imm  = 1'b1;
                mem_read = 1'b1;
                wb_sel   = wb_mem;
            end
            op_store: begin
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            op_imm: begin
                imm     = {{20{instr[31]}}, instr[31:20]};
                writes  = 1'b1;
                use_imm = 1'b1;
                alu_op  = alu_func(instr[14:12], instr[30] && instr[14:12] == 3'b101);
            end
            op_reg: begin
                writes = 1'b1;
                alu_op = alu_func(instr[14:12], instr[30]);
            end
            // unknown encodings fall through as a no-op.
            default: ;
        endcase
    end

    assign reg_write = writes && rd != 5'd0;

endmodule

`default_nettype wire

/* logic/forward_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module forward_unit
    import rv_pkg::*;
(
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  word_t    ex_rs1_val,
    input  word_t    ex_rs2_val,
    input  reg_idx_t mem_rd,
    input  reg_idx_t wb_rd,
    input  logic     mem_reg_write,
    input  logic     wb_reg_write,
    input  word_t    mem_value,
    input  word_t    wb_value,
    output word_t    fwd_a,
    output word_t    fwd_b
);

    // newest producer wins, x0 always keeps the file value.
    function automatic word_t pick(input reg_idx_t src, input word_t reg_val);
        if (src == 5'd0) return reg_val;
        if (mem_reg_write && mem_rd == src) return mem_value;
        if (wb_reg_write && wb_rd == src) return wb_value;
        return reg_val;
    endfunction

    always_comb begin
        fwd_a = pick(ex_rs1, ex_rs1_val);
        fwd_b = pick(ex_rs2, ex_rs2_val);
    end

endmodule

`default_nettype wire

/* logic/mem_align.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_align
    import rv_pkg::*;
(
    input  logic [1:0] addr_low,
    input  logic [2:0] funct3,
    input  word_t      store_data,
    input  word_t      load_word,
    output word_t      lane_data,
    output mbe_t       lane_mbe,
    output word_t      load_value
);

    word_t load_shifted;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store lane placement.
    always_comb begin
        lane_data = store_data;
        lane_mbe  = 4'b1111;
        case (funct3[1:0])
            2'b00: begin
                lane_data = {24'd0, store_data[7:0]} << {addr_low, 3'b000};
                lane_mbe  = 4'b0001 << addr_low;
            end
            2'b01: begin
                lane_data = {16'd0, store_data[15:0]} << {addr_low[1], 4'b0000};
                lane_mbe  = 4'b0011 << {addr_low[1], 1'b0};
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load extraction, wanted lane moved to the bottom first.
    assign load_shifted = load_word >> {addr_low, 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
            3'b001:  load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
            3'b100:  load_value = {24'd0, load_shifted[7:0]};
            3'b101:  load_value = {16'd0, load_shifted[15:0]};
            default: load_value = load_word;
        endcase
    end

endmodule

`default_nettype wire

/* logic/pipe_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_core
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output logic  inst_read,
    output word_t inst_addr,
    input  logic  inst_resp,
    input  word_t inst_rdata,
    output logic  data_read,
    output logic  data_write,
    output mbe_t  data_mbe,
    output word_t data_addr,
    output word_t data_wdata,
    input  logic  data_resp,
    input  word_t data_rdata
);

    logic       stall, flush;
    word_t      pc, pc_target, if_ir, if_pc;
    // decoder outputs.
    word_t      dec_instr, dec_imm, dec_rs1_val, dec_rs2_val;
    opcode_e    dec_opcode;
    reg_idx_t   dec_rd, dec_rs1, dec_rs2;
    logic [2:0] dec_funct3;
    alu_op_e    dec_alu_op;
    br_op_e     dec_br_op;
    logic       dec_use_imm, dec_use_pc, dec_reg_write, dec_mem_read, dec_mem_write;
    wb_sel_e    dec_wb_sel;
    // decode/execute register and execute results.
    opcode_e    ex_opcode;
    reg_idx_t   ex_rd, ex_rs1, ex_rs2;
    logic [2:0] ex_funct3;
    alu_op_e    ex_alu_op;
    br_op_e     ex_br_op;
    logic       ex_use_imm, ex_use_pc, ex_reg_write, ex_mem_read, ex_mem_write, br_taken;
    wb_sel_e    ex_wb_sel;
    word_t      ex_imm, ex_pc, ex_rs1_val, ex_rs2_val, fwd_a, fwd_b, alu_a, alu_b, alu_result;
    // execute/memory and memory/writeback registers.
    reg_idx_t   mem_rd, wb_rd;
    logic       mem_reg_write, mem_load, mem_store, wb_reg_write;
    logic [2:0] mem_funct3;
    wb_sel_e    mem_wb_sel;
    word_t      mem_alu, mem_wdata, mem_imm, mem_pc4, mem_value, load_value, wb_value;

    // a pending fetch or data access freezes every stage at once.
    assign stall     = !inst_resp || ((data_read || data_write) && !data_resp);
    assign flush     = (ex_opcode == op_br && br_taken) || ex_opcode == op_jal;
    assign pc_target = ex_pc + ex_imm;
    assign inst_read = 1'b1;
    assign inst_addr = pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode. a flush turns the instruction in decode into a no-op.
    assign dec_instr = flush ? nop_instr : if_ir;

    control_decode decoder (
        .instr(dec_instr), .opcode(dec_opcode), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
        .funct3(dec_funct3), .alu_op(dec_alu_op), .br_op(dec_br_op),
        .use_imm(dec_use_imm), .use_pc(dec_use_pc), .reg_write(dec_reg_write),
        .mem_read(dec_mem_read), .mem_write(dec_mem_write), .wb_sel(dec_wb_sel),
        .imm(dec_imm)
    );

    reg_file regs (
        .clk(clk), .rst_n(rst_n), .wr_en(wb_reg_write), .wr_idx(wb_rd), .wr_data(wb_value),
        .rd_idx_a(dec_rs1), .rd_idx_b(dec_rs2), .rd_data_a(dec_rs1_val),
        .rd_data_b(dec_rs2_val)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute.
    forward_unit forward (
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rs1_val(ex_rs1_val), .ex_rs2_val(ex_rs2_val),
        .mem_rd(mem_rd), .wb_rd(wb_rd), .mem_reg_write(mem_reg_write),
        .wb_reg_write(wb_reg_write), .mem_value(mem_value), .wb_value(wb_value),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    assign alu_a = ex_use_pc ? ex_pc : fwd_a;
    assign alu_b = ex_use_imm ? ex_imm : fwd_b;

    alu exec_alu (
        .a(alu_a), .b(alu_b), .cmp_b(fwd_b), .alu_op(ex_alu_op), .br_op(ex_br_op),
        .result(alu_result), .br_taken(br_taken)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory. the selected value feeds both forwarding and writeback.
    assign data_read  = mem_load;
    assign data_write = mem_store;
    assign data_addr  = {mem_alu[31:2], 2'b00};

    mem_align align (
        .addr_low(mem_alu[1:0]), .funct3(mem_funct3), .store_data(mem_wdata),
        .load_word(data_rdata), .lane_data(data_wdata), .lane_mbe(data_mbe),
        .load_value(load_value)
    );

    always_comb begin
        case (mem_wb_sel)
            wb_mem:  mem_value = load_value;
            wb_pc4:  mem_value = mem_pc4;
            wb_imm:  mem_value = mem_imm;
            default: mem_value = mem_alu;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pc and stage registers.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc            <= reset_pc;
            if_ir         <= nop_instr;
            ex_opcode     <= op_imm;
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            wb_reg_write  <= 1'b0;
        end else if (!stall) begin
            pc            <= flush ? pc_target : pc + 32'd4;
            if_ir         <= flush ? nop_instr : inst_rdata;
            ex_opcode     <= dec_opcode;
            ex_reg_write  <= dec_reg_write;
            ex_mem_read   <= dec_mem_read;
            ex_mem_write  <= dec_mem_write;
            mem_reg_write <= ex_reg_write;
            mem_load      <= ex_mem_read;
            mem_store     <= ex_mem_write;
            wb_reg_write  <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_pc      <= pc;
            ex_rd      <= dec_rd;
            ex_rs1     <= dec_rs1;
            ex_rs2     <= dec_rs2;
            ex_funct3  <= dec_funct3;
            ex_alu_op  <= dec_alu_op;
            ex_br_op   <= dec_br_op;
            ex_use_imm <= dec_use_imm;
            ex_use_pc  <= dec_use_pc;
            ex_wb_sel  <= dec_wb_sel;
            ex_imm     <= dec_imm;
            ex_pc      <= if_pc;
            ex_rs1_val <= dec_rs1_val;
            ex_rs2_val <= dec_rs2_val;
            mem_rd     <= ex_rd;
            mem_funct3 <= ex_funct3;
            mem_wb_sel <= ex_wb_sel;
            mem_alu    <= alu_result;
            mem_wdata  <= fwd_b;
            mem_imm    <= ex_imm;
            mem_pc4    <= ex_pc + 32'd4;
            wb_rd      <= mem_rd;
            wb_value   <= mem_value;
        end
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs [1:31];

    // x0 reads zero, a write in flight is returned directly.
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == 5'd0) return '0;
        if (wr_en && idx == wr_idx) return wr_data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != 5'd0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_idx_a);
        rd_data_b = read_port(rd_idx_b);
    end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  mbe_t;

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_jal   = 7'b1101111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // branch funct3 encodings, used as is.
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } br_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_imm
    } wb_sel_e;

    localparam word_t reset_pc  = 32'h0000_0000;
    // addi x0, x0, 0.
    localparam word_t nop_instr = 32'h0000_0013;

endpackage

`default_nettype wire

/* pipe_core.f */
+incdir+bench
logic/rv_pkg.sv
logic/control_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/forward_unit.sv
logic/mem_align.sv
logic/pipe_core.sv
bench/tb_pipe_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipe_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pipe_core \
    -f pipe_core.f --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

cat sim.log
if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
